/* Makefile */
# Verilator simulation of the code disk decoder

VERILATOR ?= verilator
TOP       ?= tb_encoder_top
FILELIST  ?= encoder_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* enc_pkg.sv */
// Optical encoder constants
`default_nettype none

package enc_pkg;

    // ----------------------------------------
    // Datapath widths
    // ----------------------------------------
    // Time counters
    localparam int CNT_W = 32;
    // Slot index
    localparam int SLOT_W = 8;

    // ----------------------------------------
    // Code disk geometry
    // ----------------------------------------
    // Slot positions per turn including the blank one
    localparam int SLOTS_PER_REV = 36;
    // Index of the last pulse before the gap
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(SLOTS_PER_REV - 2);

    // ----------------------------------------
    // Period averaging
    // ----------------------------------------
    localparam int AVG_EDGES = 16;
    // log2 of AVG_EDGES
    localparam int AVG_SHIFT = 4;
    // Edge count value of the last edge in a window
    localparam logic [AVG_SHIFT-1:0] AVG_LAST = AVG_SHIFT'(AVG_EDGES - 1);
    // Average period out of reset
    localparam logic [CNT_W-1:0] INIT_AVG = CNT_W'(9259);
    // 1.5 times the reset average
    localparam logic [CNT_W-1:0] INIT_THRESH = INIT_AVG + (INIT_AVG >> 1);

    // ----------------------------------------
    // Input filter and timeouts
    // ----------------------------------------
    // Equal samples needed to accept a new level
    localparam int FILTER_LEN = 3;
    localparam int FILT_CNT_W = $clog2(FILTER_LEN + 1);
    localparam logic [FILT_CNT_W-1:0] FILT_LAST = FILT_CNT_W'(FILTER_LEN - 1);
    // Idle cycles before the motor counts as stalled
    localparam logic [CNT_W-1:0] STALL_LIMIT = CNT_W'(4096);
    // Saturation value of the time counters
    localparam logic [CNT_W-1:0] CNT_MAX = '1;

endpackage

`default_nettype wire

/* encoder_calculate.sv */
// Zero index detector
`timescale 1ns/1ps
`default_nettype none

module encoder_calculate (
    input  wire  i_clk,
    input  wire  i_rst_n,
    input  wire  i_rise,
    output logic o_zero_sign
);

    // Cycles since the window opened
    logic [enc_pkg::CNT_W-1:0] r_win_cnt;
    // Rises in the current window
    logic [enc_pkg::AVG_SHIFT-1:0] r_edge_cnt;
    // Average pulse period
    logic [enc_pkg::CNT_W-1:0] r_avg;
    // Cycles since the previous rise
    logic [enc_pkg::CNT_W-1:0] r_elapsed;
    // Gap threshold at 1.5 times the average
    logic [enc_pkg::CNT_W-1:0] r_thresh;
    // Window end strobe
    logic win_done;
    // Window length including the closing cycle
    logic [enc_pkg::CNT_W-1:0] win_total;

    assign win_done  = i_rise && (r_edge_cnt == enc_pkg::AVG_LAST);
    assign win_total = r_win_cnt + 1'b1;

    // ----------------------------------------
    // Window timing
    // ----------------------------------------
    // Free running and restarted on the 16th edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_win_cnt <= '0;
        end else if (win_done) begin
            r_win_cnt <= '0;
        end else begin
            r_win_cnt <= r_win_cnt + 1'b1;
        end
    end

    // Edge count and average load
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_edge_cnt <= '0;
            r_avg      <= enc_pkg::INIT_AVG;
        end else if (win_done) begin
            r_edge_cnt <= '0;
            // Divide by AVG_EDGES
            r_avg      <= win_total >> enc_pkg::AVG_SHIFT;
        end else if (i_rise) begin
            r_edge_cnt <= r_edge_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // Gap measurement
    // ----------------------------------------
    // Saturates on a stopped disk
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_elapsed <= '0;
        end else if (i_rise) begin
            r_elapsed <= '0;
        end else if (r_elapsed != enc_pkg::CNT_MAX) begin
            r_elapsed <= r_elapsed + 1'b1;
        end
    end

    // Threshold follows the average one cycle late
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_thresh <= enc_pkg::INIT_THRESH;
        end else begin
            r_thresh <= r_avg + (r_avg >> 1);
        end
    end

    // Long gap ends on this rise
    assign o_zero_sign = i_rise && (r_elapsed >= r_thresh);

endmodule

`default_nettype wire

/* encoder_top.f */
+incdir+.
enc_pkg.sv
opto_edge_sync.sv
encoder_calculate.sv
slot_angle_counter.sv
rev_period_meter.sv
encoder_top.sv
tb_encoder_top.sv

/* encoder_top.sv */
// Code disk decoder top
`timescale 1ns/1ps
`default_nettype none

module encoder_top (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire                        i_opto_switch,
    output logic                       o_opto_rise,
    output logic                       o_zero_sign,
    output logic [enc_pkg::SLOT_W-1:0] o_slot_idx,
    output logic                       o_locked,
    output logic                       o_sync_lost,
    output logic [enc_pkg::CNT_W-1:0]  o_rev_period,
    output logic                       o_rev_valid,
    output logic                       o_stall
);

    // Filtered rising edge
    logic rise_pulse;
    // Zero index strobe
    logic zero_pulse;

    // ----------------------------------------
    // Input conditioning
    // ----------------------------------------
    opto_edge_sync sync_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_opto_switch (i_opto_switch),
        .o_rise        (rise_pulse)
    );

    // Gap detection
    encoder_calculate calc_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rise      (rise_pulse),
        .o_zero_sign (zero_pulse)
    );

    // ----------------------------------------
    // Angle and speed
    // ----------------------------------------
    slot_angle_counter slot_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rise      (rise_pulse),
        .i_zero      (zero_pulse),
        .o_slot_idx  (o_slot_idx),
        .o_locked    (o_locked),
        .o_sync_lost (o_sync_lost)
    );

    rev_period_meter rev_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_rise       (rise_pulse),
        .i_zero       (zero_pulse),
        .o_rev_period (o_rev_period),
        .o_rev_valid  (o_rev_valid),
        .o_stall      (o_stall)
    );

    // Edge strobes also go out
    assign o_opto_rise = rise_pulse;
    assign o_zero_sign = zero_pulse;

endmodule

`default_nettype wire

/* opto_edge_sync.sv */
// Opto switch edge detector
`timescale 1ns/1ps
`default_nettype none

module opto_edge_sync (
    input  wire  i_clk,
    input  wire  i_rst_n,
    input  wire  i_opto_switch,
    output logic o_rise
);

    // Synchronizer stages
    logic r_sync1;
    logic r_sync2;
    // Deglitched level
    logic r_level;
    // Run length of samples that differ from r_level
    logic [enc_pkg::FILT_CNT_W-1:0] r_stable_cnt;

    // ----------------------------------------
    // Two flop synchronizer
    // ----------------------------------------
    // Idle level of the opto switch is high
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_sync1 <= 1'b1;
            r_sync2 <= 1'b1;
        end else begin
            r_sync1 <= i_opto_switch;
            r_sync2 <= r_sync1;
        end
    end

    // ----------------------------------------
    // Stability filter and rise pulse
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_level      <= 1'b1;
            r_stable_cnt <= '0;
            o_rise       <= 1'b0;
        end else begin
            // Default no edge
            o_rise <= 1'b0;
            if (r_sync2 == r_level) begin
                // Sample agrees with level so drop partial run
                r_stable_cnt <= '0;
            end else if (r_stable_cnt == enc_pkg::FILT_LAST) begin
                // FILTER_LEN equal samples seen
                r_stable_cnt <= '0;
                r_level      <= r_sync2;
                // Pulse only on 0 to 1
                o_rise       <= r_sync2;
            end else begin
                r_stable_cnt <= r_stable_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rev_period_meter.sv */
// Revolution period and stall meter
`timescale 1ns/1ps
`default_nettype none

module rev_period_meter (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire                        i_rise,
    input  wire                        i_zero,
    output logic [enc_pkg::CNT_W-1:0]  o_rev_period,
    output logic                       o_rev_valid,
    output logic                       o_stall
);

    // Cycles since the last zero sign
    logic [enc_pkg::CNT_W-1:0] r_cyc_cnt;
    // Cycles since the last rise
    logic [enc_pkg::CNT_W-1:0] r_idle_cnt;
    // A reference zero exists
    logic r_seen_zero;
    // Revolution length including the zero cycle
    logic [enc_pkg::CNT_W-1:0] rev_len;

    assign rev_len = (r_cyc_cnt == enc_pkg::CNT_MAX) ? enc_pkg::CNT_MAX : r_cyc_cnt + 1'b1;

    // ----------------------------------------
    // Revolution timing
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_cyc_cnt <= '0;
        end else if (i_zero) begin
            r_cyc_cnt <= '0;
        end else if (r_cyc_cnt != enc_pkg::CNT_MAX) begin
            r_cyc_cnt <= r_cyc_cnt + 1'b1;
        end
    end

    // Latch on each zero after the first
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_seen_zero  <= 1'b0;
            o_rev_period <= '0;
            o_rev_valid  <= 1'b0;
        end else begin
            o_rev_valid <= 1'b0;
            if (i_zero) begin
                r_seen_zero <= 1'b1;
                if (r_seen_zero) begin
                    o_rev_period <= rev_len;
                    o_rev_valid  <= 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Stall detection
    // ----------------------------------------
    // Holds at the limit while idle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_idle_cnt <= '0;
        end else if (i_rise) begin
            r_idle_cnt <= '0;
        end else if (r_idle_cnt != enc_pkg::STALL_LIMIT) begin
            r_idle_cnt <= r_idle_cnt + 1'b1;
        end
    end

    assign o_stall = (r_idle_cnt == enc_pkg::STALL_LIMIT);

endmodule

`default_nettype wire

/* slot_angle_counter.sv */
// Slot index counter
`timescale 1ns/1ps
`default_nettype none

module slot_angle_counter (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_rise,
    input  wire                         i_zero,
    output logic [enc_pkg::SLOT_W-1:0]  o_slot_idx,
    output logic                        o_locked,
    output logic                        o_sync_lost
);

    // Zero sign came too early
    logic short_rev;
    // Extra pulse where the gap should be
    logic long_rev;

    assign short_rev = i_zero && (o_slot_idx != enc_pkg::LAST_SLOT);
    assign long_rev  = i_rise && !i_zero && (o_slot_idx == enc_pkg::LAST_SLOT);

    // ----------------------------------------
    // Slot index
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_slot_idx <= '0;
        end else if (i_zero) begin
            // Realign on every zero sign
            o_slot_idx <= '0;
        end else if (i_rise) begin
            o_slot_idx <= o_slot_idx + 1'b1;
        end
    end

    // ----------------------------------------
    // Lock tracking
    // ----------------------------------------
    // Set by the first zero sign
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_locked <= 1'b0;
        end else if (i_zero) begin
            o_locked <= 1'b1;
        end
    end

    // Pulse count check between zero signs
    // Sticky until reset
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_sync_lost <= 1'b0;
        end else if (o_locked && (short_rev || long_rev)) begin
            o_sync_lost <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tb_encoder_ref.svh */
// Code disk stimulus and reference model
`ifndef TB_ENCODER_REF_SVH
`define TB_ENCODER_REF_SVH

// Pulses per turn, the blank slot gives none
localparam int PULSES = enc_pkg::SLOTS_PER_REV - 1;

// ----------------------------------------
// Stimulus
// ----------------------------------------
// Hold the opto input, called on a rising edge
task automatic drive_level(input logic lvl, input int cycles);
    opto <= lvl;
    repeat (cycles) @(posedge clk);
endtask

// One slot, dark then lit
task automatic drive_slot(input int p);
    drive_level(1'b0, p - p / 2);
    drive_level(1'b1, p / 2);
endtask

// Full turn, skip below zero keeps every slot
task automatic drive_rev(input int p, input int skip);
    for (int i = 0; i < PULSES; i++) begin
        if (i == skip) begin
            drive_level(1'b0, p);
        end else begin
            drive_slot(p);
        end
    end
    // Blank slot, rise to rise is 2P across it
    drive_level(1'b0, p);
endtask

// ----------------------------------------
// Reference model
// ----------------------------------------
// Rise n of a clean run opens a turn after a gap
function automatic logic is_zero_rise(input int n);
    return (n > 0) && (n % PULSES == 0);
endfunction

// Rises since the last zero
function automatic logic [enc_pkg::SLOT_W-1:0] exp_slot(input int n);
    int idx;
    idx = n % PULSES;
    return idx[enc_pkg::SLOT_W-1:0];
endfunction

// A turn spans every slot position
function automatic logic [enc_pkg::CNT_W-1:0] exp_rev_period(input int p);
    int cyc;
    cyc = enc_pkg::SLOTS_PER_REV * p;
    return cyc[enc_pkg::CNT_W-1:0];
endfunction

`endif

/* tb_encoder_top.sv */
// Code disk decoder testbench
`timescale 1ns/1ps
`default_nettype none

module tb_encoder_top;

    localparam int CLK_NS = 4;
    localparam int SEED = 32'h2d19_42c2;
    // Slot period range in cycles
    localparam int P_MIN = 40;
    localparam int P_MAX = 80;
    localparam int ROT_REVS = 5;
    localparam int EDGE_PULSES = 20;
    localparam int DARK = 10;
    localparam int STALL_HOLD = int'(enc_pkg::STALL_LIMIT) + 200;
    // Worst case cycles of all tests including resets
    localparam longint TEST_CYCLES = EDGE_PULSES * (2 * DARK + enc_pkg::FILTER_LEN + 2)
        + (3 * ROT_REVS + 4 + 1) * enc_pkg::SLOTS_PER_REV * P_MAX
        + STALL_HOLD + 4 * P_MAX + 6 * 64;

    logic clk;
    logic rst_n;
    logic opto;
    logic opto_rise, zero_sign, locked, sync_lost, rev_valid, stall;
    logic [enc_pkg::SLOT_W-1:0] slot_idx;
    logic [enc_pkg::CNT_W-1:0] rev_period;

    // Monitor state
    int period;
    int rise_num;
    int valid_num;
    logic chk_zero, chk_slot, chk_rev;
    logic slot_pend;
    logic [enc_pkg::SLOT_W-1:0] slot_exp;
    logic stall_at_rise;
    // Bookkeeping
    int err_cnt;
    int err_base;
    int tests_run;
    int tests_failed;

    `include "tb_encoder_ref.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    encoder_top dut_i (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_opto_switch (opto),
        .o_opto_rise   (opto_rise),
        .o_zero_sign   (zero_sign),
        .o_slot_idx    (slot_idx),
        .o_locked      (locked),
        .o_sync_lost   (sync_lost),
        .o_rev_period  (rev_period),
        .o_rev_valid   (rev_valid),
        .o_stall       (stall)
    );

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_slot(input string name, input logic [enc_pkg::SLOT_W-1:0] got,
                              input logic [enc_pkg::SLOT_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_cycles(input string name, input logic [enc_pkg::CNT_W-1:0] got,
                                input logic [enc_pkg::CNT_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
            err_cnt++;
        end
    endtask

    // ----------------------------------------
    // Monitor sampled mid cycle
    // ----------------------------------------
    always @(negedge clk) begin
        if (!rst_n) begin
            rise_num = 0;
            valid_num = 0;
            slot_pend = 1'b0;
            stall_at_rise = 1'b0;
        end else begin
            // Index lands one cycle after its rise
            if (slot_pend) begin
                check_slot("o_slot_idx", slot_idx, slot_exp);
                check_flag("o_locked", locked, 1'b1);
                slot_pend = 1'b0;
            end
            if (opto_rise) begin
                // From the third turn on
                if (chk_zero && rise_num >= 2 * PULSES) begin
                    check_flag("o_zero_sign", zero_sign, is_zero_rise(rise_num));
                end
                if (chk_slot && rise_num >= 2 * PULSES) begin
                    slot_pend = 1'b1;
                    slot_exp = exp_slot(rise_num);
                end
                stall_at_rise = stall;
                rise_num++;
            end
            if (rev_valid) begin
                valid_num++;
                if (chk_rev) begin
                    check_cycles("o_rev_period", rev_period, exp_rev_period(period));
                end
            end
        end
    end

    // ----------------------------------------
    // Test sequencing
    // ----------------------------------------
    // Reset for 3 cycles and draw a new slot period
    task automatic start_test();
        rst_n <= 1'b0;
        opto <= 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        period = P_MIN + int'($urandom % (P_MAX - P_MIN + 1));
        err_base = err_cnt;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt == err_base) begin
            $display("test %0d %s: ok, period %0d", tests_run, name, period);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_base);
        end
    endtask

    task automatic wait_for_rises(input int target, input int limit);
        int waited;
        waited = 0;
        while (rise_num < target && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (rise_num < target) begin
            $display("Timed out after %0d cycles waiting for opto rise %0d", limit, target);
            err_cnt++;
        end
    endtask

    task automatic edge_test();
        start_test();
        for (int i = 0; i < EDGE_PULSES; i++) begin
            drive_level(1'b0, DARK);
            // One cycle glitch inside the dark time
            drive_level(1'b1, 1);
            drive_level(1'b0, DARK);
            drive_level(1'b1, enc_pkg::FILTER_LEN + 1);
        end
        drive_level(1'b0, DARK);
        wait_for_rises(EDGE_PULSES, DARK);
        check_cycles("o_opto_rise count", rise_num, EDGE_PULSES);
        end_test("edge filter");
    endtask

    task automatic rotation_test(input string name, input logic zero_on, input logic slot_on,
                                 input logic rev_on);
        logic [enc_pkg::CNT_W-1:0] exp_valid;
        start_test();
        chk_zero = zero_on;
        chk_slot = slot_on;
        chk_rev = rev_on;
        repeat (ROT_REVS) drive_rev(period, -1);
        chk_zero = 1'b0;
        chk_slot = 1'b0;
        chk_rev = 1'b0;
        @(negedge clk);
        check_flag("o_locked", locked, 1'b1);
        check_flag("o_sync_lost", sync_lost, 1'b0);
        // Zeros open turns 1 and up
        // The first zero gives no period
        exp_valid = ROT_REVS - 2;
        if (rev_on) begin
            check_cycles("o_rev_valid count", valid_num, exp_valid);
        end
        @(posedge clk);
        end_test(name);
    endtask

    task automatic sync_lost_test();
        start_test();
        repeat (2) drive_rev(period, -1);
        @(negedge clk);
        check_flag("o_sync_lost", sync_lost, 1'b0);
        @(posedge clk);
        // Second long gap in the middle of a turn
        drive_rev(period, PULSES / 2);
        drive_rev(period, -1);
        @(negedge clk);
        check_flag("o_sync_lost", sync_lost, 1'b1);
        @(posedge clk);
        end_test("lost sync");
    endtask

    task automatic stall_test();
        int mark;
        start_test();
        drive_rev(period, -1);
        // Disk stops in a dark slot
        drive_level(1'b0, STALL_HOLD);
        @(negedge clk);
        check_flag("o_stall", stall, 1'b1);
        @(posedge clk);
        mark = rise_num;
        repeat (2) drive_slot(period);
        drive_level(1'b0, period);
        wait_for_rises(mark + 2, 4 * P_MAX);
        check_flag("o_stall at second rise", stall_at_rise, 1'b0);
        end_test("stall");
    endtask

    initial begin
        rst_n = 1'b0;
        opto = 1'b1;
        chk_zero = 1'b0;
        chk_slot = 1'b0;
        chk_rev = 1'b0;
        err_cnt = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(SEED));
        edge_test();
        rotation_test("zero index", 1'b1, 1'b0, 1'b0);
        rotation_test("slot index", 1'b0, 1'b1, 1'b0);
        rotation_test("revolution period", 1'b0, 1'b0, 1'b1);
        sync_lost_test();
        stall_test();
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog at twice the worst case run time
    initial begin
        #(TEST_CYCLES * 2 * CLK_NS);
        $display("Watchdog expired after %0d cycles, run did not finish", TEST_CYCLES * 2);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
